//--- files.f
logic/cache_cfg_pkg.sv
logic/fetch_pkg.sv
logic/sdp_ram.sv
logic/pc_stage.sv
logic/i_cache.sv
logic/fetch_top.sv
verif/mem_burst_model.sv
verif/tb_fetch.sv

//--- logic/cache_cfg_pkg.sv
`default_nettype none

package cache_cfg_pkg;

    // default geometry, 4 KB per way
    localparam int TAG_WIDTH_DEF    = 20;
    localparam int INDEX_WIDTH_DEF  = 7;
    localparam int OFFSET_WIDTH_DEF = 5;  // byte offset in a line, at least 3
    localparam int WAY_NUM_DEF      = 4;  // power of two

    // 32-bit words held by one line
    function automatic int words_per_line(input int offset_width);
        return 1 << (offset_width - 2);
    endfunction

    // bits needed to name one way
    function automatic int way_idx_width(input int way_num);
        return (way_num > 1) ? $clog2(way_num) : 1;
    endfunction

endpackage

`default_nettype wire

//--- logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    localparam logic [31:0] RESET_PC = 32'h0000_1000;  // first fetch address

    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int BURST_LEN_W = 8;   // arlen width

    // cache controller states
    typedef enum logic [1:0] {
        idle        = 2'b00,
        hit_judge   = 2'b01,
        load_memory = 2'b11
    } cache_state_e;

endpackage

`default_nettype wire

//--- logic/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
    parameter int TAG_WIDTH    = cache_cfg_pkg::TAG_WIDTH_DEF,
    parameter int INDEX_WIDTH  = cache_cfg_pkg::INDEX_WIDTH_DEF,
    parameter int OFFSET_WIDTH = cache_cfg_pkg::OFFSET_WIDTH_DEF,
    parameter int WAY_NUM      = cache_cfg_pkg::WAY_NUM_DEF
) (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              fetch_en,
    input  wire logic                              redirect,
    input  wire logic [fetch_pkg::ADDR_W-1:0]      redirect_pc,
    output logic                                   inst_valid,
    output logic      [fetch_pkg::ADDR_W-1:0]      inst_pc,
    output logic      [fetch_pkg::DATA_W-1:0]      inst_data,
    // read bus toward memory
    output logic      [fetch_pkg::ADDR_W-1:0]      araddr,
    output logic      [fetch_pkg::BURST_LEN_W-1:0] arlen,
    output logic                                   arvalid,
    input  wire logic                              arready,
    input  wire logic [fetch_pkg::DATA_W-1:0]      rdata,
    input  wire logic                              rlast,
    input  wire logic                              rvalid,
    output logic                                   rready
);

    import fetch_pkg::*;

    logic [ADDR_W-1:0] pc_f;
    logic [ADDR_W-1:0] pc_next;
    logic              stall;

    assign inst_valid = fetch_en && !stall;
    assign inst_pc    = pc_f;

    pc_stage u_pc_stage (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_en    (fetch_en),
        .pc_f        (pc_f),
        .pc_next     (pc_next)
    );

    i_cache #(
        .TAG_WIDTH    (TAG_WIDTH),
        .INDEX_WIDTH  (INDEX_WIDTH),
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .WAY_NUM      (WAY_NUM)
    ) u_i_cache (
        .clk        (clk),
        .rst        (rst),
        .inst_en    (fetch_en),
        .pc_next    (pc_next),
        .pc_f       (pc_f),
        .inst_rdata (inst_data),
        .stall      (stall),
        .araddr     (araddr),
        .arlen      (arlen),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rlast      (rlast),
        .rvalid     (rvalid),
        .rready     (rready)
    );

endmodule

`default_nettype wire

//--- logic/i_cache.sv
`timescale 1ns/1ps
`default_nettype none

module i_cache #(
    parameter int TAG_WIDTH    = cache_cfg_pkg::TAG_WIDTH_DEF,
    parameter int INDEX_WIDTH  = cache_cfg_pkg::INDEX_WIDTH_DEF,
    parameter int OFFSET_WIDTH = cache_cfg_pkg::OFFSET_WIDTH_DEF,
    parameter int WAY_NUM      = cache_cfg_pkg::WAY_NUM_DEF
) (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              inst_en,
    input  wire logic [fetch_pkg::ADDR_W-1:0]      pc_next,
    input  wire logic [fetch_pkg::ADDR_W-1:0]      pc_f,
    output logic      [fetch_pkg::DATA_W-1:0]      inst_rdata,
    output logic                                   stall,
    output logic      [fetch_pkg::ADDR_W-1:0]      araddr,
    output logic      [fetch_pkg::BURST_LEN_W-1:0] arlen,
    output logic                                   arvalid,
    input  wire logic                              arready,
    input  wire logic [fetch_pkg::DATA_W-1:0]      rdata,
    input  wire logic                              rlast,
    input  wire logic                              rvalid,
    output logic                                   rready
);

    import fetch_pkg::*;
    import cache_cfg_pkg::*;

    localparam int WORDS  = words_per_line(OFFSET_WIDTH);
    localparam int WORD_W = OFFSET_WIDTH - 2;
    localparam int WAY_W  = way_idx_width(WAY_NUM);
    localparam int SETS   = 1 << INDEX_WIDTH;

    // address fields
    logic [TAG_WIDTH-1:0]   tag;
    logic [INDEX_WIDTH-1:0] index;
    logic [INDEX_WIDTH-1:0] index_next;
    logic [WORD_W-1:0]      offset;

    assign tag        = pc_f[ADDR_W-1 -: TAG_WIDTH];
    assign index      = pc_f[OFFSET_WIDTH +: INDEX_WIDTH];
    assign index_next = pc_next[OFFSET_WIDTH +: INDEX_WIDTH];
    assign offset     = pc_f[2 +: WORD_W];  // word within the line

    // RAM outputs, tag entry is {tag, valid}
    logic [TAG_WIDTH:0]  tag_q  [WAY_NUM];
    logic [DATA_W-1:0]   word_q [WAY_NUM][WORDS];

    logic [WAY_NUM-1:0]  hit_mask;
    logic                hit;
    logic [WAY_W-1:0]    hit_way;
    logic [DATA_W-1:0]   hit_word;

    logic [WAY_W-1:0]    victim_ptr [SETS];
    logic [WAY_W-1:0]    victim;

    cache_state_e        state;
    cache_state_e        state_nx;

    logic                sweep_busy;
    logic [INDEX_WIDTH-1:0] sweep_idx;
    logic                first_cycle;
    logic                refill_done;   // captured word ready in idle
    logic [WORD_W-1:0]   beat_cnt;
    logic [DATA_W-1:0]   saved_word;

    logic                miss_start;
    logic                beat;
    logic                fill_end;

    logic                ram_re;
    logic [INDEX_WIDTH-1:0] ram_raddr;
    logic [WAY_NUM-1:0]  tag_we;
    logic [INDEX_WIDTH-1:0] tag_waddr;
    logic [TAG_WIDTH:0]  tag_wdata;

    // tag compare across all ways
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            hit_mask[w] = tag_q[w][0] && (tag_q[w][TAG_WIDTH:1] == tag);
            if (hit_mask[w]) begin
                hit_way = hit_way | WAY_W'(w);  // mask is one-hot
            end
        end
    end

    assign hit      = |hit_mask;
    assign hit_word = word_q[hit_way][offset];
    assign victim   = victim_ptr[index];

    assign miss_start = (state == hit_judge) && inst_en && !hit;
    assign beat       = rready && rvalid;
    assign fill_end   = beat && rlast;

    always_comb begin
        state_nx = state;
        case (state)
            idle: begin
                if (!sweep_busy) begin
                    state_nx = hit_judge;
                end
            end
            hit_judge: begin
                if (miss_start) begin
                    state_nx = load_memory;
                end
            end
            load_memory: begin
                if (fill_end) begin
                    state_nx = idle;
                end
            end
            default: state_nx = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= state_nx;
        end
    end

    // idle hands out the captured word once after a fill
    always_comb begin
        case (state)
            idle:      stall = !refill_done;
            hit_judge: stall = !hit;
            default:   stall = 1'b1;
        endcase
    end

    assign inst_rdata = (state == hit_judge) ? hit_word : saved_word;

    // reset sweep clears every tag entry
    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_busy <= 1'b1;
            sweep_idx  <= '0;
        end else if (sweep_busy) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == '1) begin
                sweep_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            first_cycle <= 1'b1;
        end else begin
            first_cycle <= 1'b0;
        end
    end

    // bus side, one burst at a time
    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid     <= 1'b0;
            rready      <= 1'b0;
            beat_cnt    <= '0;
            refill_done <= 1'b0;
        end else begin
            if (miss_start) begin
                arvalid <= 1'b1;
            end else if (arvalid && arready) begin
                arvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                rready <= 1'b1;
            end else if (fill_end) begin
                rready <= 1'b0;
            end
            if (fill_end) begin
                beat_cnt <= '0;
            end else if (beat) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            refill_done <= fill_end;
        end
    end

    always_ff @(posedge clk) begin
        if (beat && beat_cnt == offset) begin
            saved_word <= rdata;    // requested word
        end
    end

    assign araddr = {tag, index, {OFFSET_WIDTH{1'b0}}};  // line aligned
    assign arlen  = BURST_LEN_W'(WORDS - 1);

    // victim becomes the inverse of the way just used
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                victim_ptr[s] <= '0;
            end
        end else if (inst_en && state == hit_judge && hit) begin
            victim_ptr[index] <= ~hit_way;
        end else if (fill_end) begin
            victim_ptr[index] <= ~victim;
        end
    end

    assign ram_re    = !stall || (state == idle);
    assign ram_raddr = first_cycle ? index : index_next;

    always_comb begin
        for (int w = 0; w < WAY_NUM; w++) begin
            tag_we[w] = sweep_busy || (fill_end && victim == WAY_W'(w));
        end
    end

    assign tag_waddr = sweep_busy ? sweep_idx : index;
    assign tag_wdata = sweep_busy ? '0 : {tag, 1'b1};

    for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
        sdp_ram #(
            .ADDR_W (INDEX_WIDTH),
            .DATA_W (TAG_WIDTH + 1)
        ) u_tag_ram (
            .clk   (clk),
            .we    (tag_we[w]),
            .waddr (tag_waddr),
            .wdata (tag_wdata),
            .re    (ram_re),
            .raddr (ram_raddr),
            .rdata (tag_q[w])
        );

        for (genvar j = 0; j < WORDS; j++) begin : g_word
            logic bank_we;  // this beat lands in this bank

            assign bank_we = beat && (victim == WAY_W'(w)) && (beat_cnt == WORD_W'(j));

            sdp_ram #(
                .ADDR_W (INDEX_WIDTH),
                .DATA_W (DATA_W)
            ) u_data_ram (
                .clk   (clk),
                .we    (bank_we),
                .waddr (index),
                .wdata (rdata),
                .re    (ram_re),
                .raddr (ram_raddr),
                .rdata (word_q[w][j])
            );
        end
    end

endmodule

`default_nettype wire

//--- logic/pc_stage.sv
`timescale 1ns/1ps
`default_nettype none

module pc_stage (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         stall,
    input  wire logic                         redirect,
    input  wire logic [fetch_pkg::ADDR_W-1:0] redirect_pc,
    input  wire logic                         fetch_en,
    output logic      [fetch_pkg::ADDR_W-1:0] pc_f,
    output logic      [fetch_pkg::ADDR_W-1:0] pc_next
);

    import fetch_pkg::*;

    logic advance;  // an instruction leaves the fetch stage this cycle

    assign advance = fetch_en && !stall;

    // next address goes straight to the cache RAM read port
    always_comb begin
        if (advance && redirect) begin
            pc_next = redirect_pc;
        end else if (advance) begin
            pc_next = pc_f + ADDR_W'(4);
        end else begin
            pc_next = pc_f;     // hold on stall or idle fetch
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_f <= RESET_PC;
        end else begin
            pc_f <= pc_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/sdp_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sdp_ram #(
    parameter int ADDR_W = 7,
    parameter int DATA_W = 32
) (
    input  wire logic              clk,
    input  wire logic              we,
    input  wire logic [ADDR_W-1:0] waddr,
    input  wire logic [DATA_W-1:0] wdata,
    input  wire logic              re,
    input  wire logic [ADDR_W-1:0] raddr,
    output logic      [DATA_W-1:0] rdata
);

    logic [DATA_W-1:0] mem [1 << ADDR_W];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

//--- verif/mem_burst_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_burst_model (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic [fetch_pkg::ADDR_W-1:0]      araddr,
    input  wire logic [fetch_pkg::BURST_LEN_W-1:0] arlen,
    input  wire logic                              arvalid,
    output logic                                   arready,
    output logic      [fetch_pkg::DATA_W-1:0]      rdata,
    output logic                                   rlast,
    output logic                                   rvalid,
    input  wire logic                              rready
);

    import fetch_pkg::*;

    localparam logic [31:0] CONTENT_KEY = 32'hA5A5_0000;

    logic [ADDR_W-1:0] line_addr;
    int                burst_len;
    int                gap;

    // memory image, word at A is A xor key
    function automatic logic [DATA_W-1:0] word_at(input logic [ADDR_W-1:0] addr);
        return addr ^ CONTENT_KEY;
    endfunction

    // all outputs change on the falling edge
    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
        forever begin
            @(negedge clk);
            if (!rst && arvalid) begin
                gap = $urandom % 4;
                repeat (gap) @(negedge clk);  // address wait
                line_addr = araddr;
                burst_len = int'(arlen);
                arready   = 1'b1;
                @(negedge clk);
                arready = 1'b0;
                for (int i = 0; i <= burst_len; i++) begin
                    gap = $urandom % 4;
                    repeat (gap) @(negedge clk);  // rvalid bubble
                    rvalid = 1'b1;
                    rdata  = word_at(line_addr + ADDR_W'(i * 4));
                    rlast  = (i == burst_len);
                    @(posedge clk);
                    while (!rready) begin
                        @(posedge clk);
                    end
                    @(negedge clk);
                    rvalid = 1'b0;
                    rlast  = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch;

    import fetch_pkg::*;
    import cache_cfg_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int SEED       = 99;
    localparam int OFF_W      = OFFSET_WIDTH_DEF;
    localparam int IDX_W      = INDEX_WIDTH_DEF;
    localparam int WAYS       = WAY_NUM_DEF;
    localparam int TAG_W      = ADDR_W - OFF_W - IDX_W;
    localparam int WAY_BITS   = $clog2(WAYS);
    localparam int SETS       = 1 << IDX_W;
    localparam int LINE_BYTES = 1 << OFF_W;
    localparam int LINE_WORDS = LINE_BYTES / 4;
    localparam int RAND_JUMPS = 20;
    localparam logic [31:0] CONTENT_KEY = 32'hA5A5_0000;
    localparam logic [31:0] LOOP_BASE   = 32'h0000_8200;  // sets 0x10 to 0x15
    localparam logic [31:0] LOOP_LAST   = LOOP_BASE + 6 * LINE_BYTES - 4;
    localparam logic [31:0] SAME_BASE   = 32'h0001_0800;  // set 0x40
    localparam logic [31:0] TAG_STEP    = 32'h1 << (OFF_W + IDX_W);
    localparam logic [31:0] RAND_BASE   = 32'h0002_0000;
    // fetches over all phases and a fill with every gap at its longest
    localparam int FETCH_BUDGET = (12 + 12 + 15 + 1) * LINE_WORDS + RAND_JUMPS * 12;
    localparam int FILL_CYCLES  = 4 + 4 * LINE_WORDS + 2;
    localparam int WATCHDOG_NS  = (FETCH_BUDGET * FILL_CYCLES * 2 + SETS + 8) * CLK_PERIOD;

    logic                   clk;
    logic                   rst;
    logic                   fetch_en;
    logic                   redirect;
    logic [ADDR_W-1:0]      redirect_pc;
    logic                   inst_valid;
    logic [ADDR_W-1:0]      inst_pc;
    logic [DATA_W-1:0]      inst_data;
    logic [ADDR_W-1:0]      araddr;
    logic [BURST_LEN_W-1:0] arlen;
    logic                   arvalid;
    logic                   arready;
    logic [DATA_W-1:0]      rdata;
    logic                   rlast;
    logic                   rvalid;
    logic                   rready;

    logic [ADDR_W-1:0]   expected_pc;
    int                  fetch_count;
    int                  bursts_seen;
    int                  bursts_expected;
    logic                burst_open;
    logic                no_fill_window;   // second loop pass
    logic [TAG_W-1:0]    model_tag   [SETS][WAYS];
    logic                model_valid [SETS][WAYS];
    logic [WAY_BITS-1:0] model_ptr   [SETS];
    cache_state_e        dbg_state;

    assign dbg_state = u_fetch_top.u_i_cache.state;

    fetch_top u_fetch_top (
        .clk (clk), .rst (rst), .fetch_en (fetch_en),
        .redirect (redirect), .redirect_pc (redirect_pc),
        .inst_valid (inst_valid), .inst_pc (inst_pc), .inst_data (inst_data),
        .araddr (araddr), .arlen (arlen), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rlast (rlast), .rvalid (rvalid), .rready (rready)
    );

    mem_burst_model u_mem_burst_model (
        .clk (clk), .rst (rst), .araddr (araddr), .arlen (arlen),
        .arvalid (arvalid), .arready (arready), .rdata (rdata),
        .rlast (rlast), .rvalid (rvalid), .rready (rready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Verification failed");
        $display("Watchdog expired at %0t ns, instructions stopped arriving", $time);
        $fatal(1);
    end

    task automatic fail_run(input string msg);
        $display("Verification failed");
        $display("** Error @ %0t ns: %s (cache state %s)", $time, msg, dbg_state.name());
        $fatal(1);
    endtask

    // reference cache where the new victim is the inverse of the way used
    task automatic model_access(input logic [ADDR_W-1:0] addr);
        logic [IDX_W-1:0]    set_idx;
        logic [TAG_W-1:0]    line_tag;
        logic [WAY_BITS-1:0] way;
        logic                found;

        set_idx  = addr[OFF_W +: IDX_W];
        line_tag = addr[ADDR_W-1 -: TAG_W];
        way      = model_ptr[set_idx];
        found    = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (model_valid[set_idx][w] && model_tag[set_idx][w] == line_tag) begin
                found = 1'b1;
                way   = WAY_BITS'(w);
            end
        end
        if (!found) begin
            model_valid[set_idx][way] = 1'b1;
            model_tag[set_idx][way]   = line_tag;
            bursts_expected           = bursts_expected + 1;
        end
        model_ptr[set_idx] = ~way;
    endtask

    task automatic wait_fetches(input int n);
        int target;

        target = fetch_count + n;
        while (fetch_count < target) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_for_pc(input logic [ADDR_W-1:0] pc);
        while (inst_pc != pc) begin
            @(negedge clk);
        end
    endtask

    // entered on a falling edge and holds redirect until it is taken
    task automatic jump_to(input logic [ADDR_W-1:0] target);
        redirect    = 1'b1;
        redirect_pc = target;
        @(posedge clk);
        while (!inst_valid) begin
            @(posedge clk);
        end
        @(negedge clk);
        redirect = 1'b0;
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (inst_valid) begin
                assert (inst_data == (inst_pc ^ CONTENT_KEY))
                    else fail_run($sformatf("inst_data 0x%08h at pc 0x%08h, expected 0x%08h",
                                            inst_data, inst_pc, inst_pc ^ CONTENT_KEY));
                assert (inst_pc == expected_pc)
                    else fail_run($sformatf("inst_pc 0x%08h, expected 0x%08h",
                                            inst_pc, expected_pc));
                expected_pc = redirect ? redirect_pc : expected_pc + 32'd4;
                model_access(inst_pc);
                fetch_count = fetch_count + 1;
            end
            if (!fetch_en) begin
                assert (!inst_valid) else fail_run("inst_valid high while fetch_en is low");
            end
            // rready covers acceptance up to the rlast beat
            assert (rready == burst_open)
                else fail_run($sformatf("rready %0b, expected %0b", rready, burst_open));
            if (burst_open) begin
                assert (!arvalid) else fail_run("arvalid raised while a burst is outstanding");
            end
            if (arvalid && arready) begin
                assert (araddr[OFF_W-1:0] == '0)
                    else fail_run($sformatf("araddr 0x%08h not line aligned", araddr));
                assert (arlen == BURST_LEN_W'(LINE_WORDS - 1))
                    else fail_run($sformatf("arlen %0d, expected %0d", arlen, LINE_WORDS - 1));
                assert (!no_fill_window)
                    else fail_run($sformatf("refill of 0x%08h in second loop pass", araddr));
                bursts_seen = bursts_seen + 1;
                burst_open  = 1'b1;
            end
            if (rvalid && rready && rlast) begin
                burst_open = 1'b0;
            end
        end
    end

    initial begin
        logic [ADDR_W-1:0] line;
        logic [ADDR_W-1:0] next_line;
        int                seed_val;

        seed_val        = $urandom(SEED);
        rst             = 1'b1;
        fetch_en        = 1'b0;
        redirect        = 1'b0;
        redirect_pc     = '0;
        expected_pc     = RESET_PC;  // first fetch after reset
        fetch_count     = 0;
        bursts_seen     = 0;
        bursts_expected = 0;
        burst_open      = 1'b0;
        no_fill_window  = 1'b0;
        for (int s = 0; s < SETS; s++) begin
            model_ptr[s] = '0;
            for (int w = 0; w < WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w]   = '0;
            end
        end
        repeat (8) @(negedge clk);
        rst      = 1'b0;
        fetch_en = 1'b1;

        wait_fetches(12 * LINE_WORDS);  // straight run from RESET_PC

        // 6-line loop whose second pass must hit throughout
        jump_to(LOOP_BASE);
        wait_for_pc(LOOP_LAST);
        jump_to(LOOP_BASE);
        no_fill_window = 1'b1;
        wait_for_pc(LOOP_LAST);
        jump_to(SAME_BASE);
        no_fill_window = 1'b0;

        // five lines in one set over three rounds
        for (int r = 0; r < 3; r++) begin
            for (int k = 0; k < 5; k++) begin
                line      = SAME_BASE + 32'(k) * TAG_STEP;
                next_line = (k == 4) ? SAME_BASE : line + TAG_STEP;
                if (r == 2 && k == 4) begin
                    next_line = RAND_BASE;
                end
                wait_for_pc(line + LINE_BYTES - 4);
                jump_to(next_line);
            end
        end
        assert (bursts_seen == bursts_expected)
            else fail_run($sformatf("%0d bursts after rotation, victim model expects %0d",
                                    bursts_seen, bursts_expected));

        for (int j = 0; j < RAND_JUMPS; j++) begin
            wait_fetches(1 + $urandom % 12);
            jump_to(RAND_BASE + ((32'($urandom) % 2048) << 2));
        end
        wait_fetches(LINE_WORDS);
        fetch_en = 1'b0;
        assert (bursts_seen == bursts_expected)
            else fail_run($sformatf("%0d bursts in total, victim model expects %0d",
                                    bursts_seen, bursts_expected));
        repeat (4) @(negedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire
